//--- testbench/fp_div_ref.svh
`ifndef FP_DIV_REF_SVH
`define FP_DIV_REF_SVH

// ==============================
// Random source
// ==============================
// 16-bit Fibonacci LFSR with taps 16 14 13 11
logic [15:0] lfsr_state = 16'd16;

// Steps once per bit and shifts each new bit in at the bottom
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  logic        fb;
  v = '0;
  for (int i = 0; i < n; i++) begin
    fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    v          = {v[30:0], fb};
  end
  return v;
endfunction

// Exponent leans to 0, 255, the bias and the edges of the normal range
function automatic logic [31:0] gen_operand();
  logic        sign;
  logic [2:0]  sel;
  logic [7:0]  exp_f;
  logic [22:0] frac;
  sign = 1'(rand_bits(1));
  sel  = 3'(rand_bits(3));
  case (sel)
    3'd0:       exp_f = 8'd0;
    3'd1:       exp_f = 8'd255;
    3'd2, 3'd3: exp_f = 8'(EXP_BIAS - 8 + rand_bits(4));
    3'd4:       exp_f = 8'(1 + rand_bits(3));
    3'd5:       exp_f = 8'(246 + rand_bits(3));
    default:    exp_f = 8'(rand_bits(8));
  endcase
  frac = 23'(rand_bits(23));
  // Clear fraction now and then to hit zero and infinity
  if (rand_bits(2) == 0) begin
    frac = '0;
  end
  return {sign, exp_f, frac};
endfunction

// ==============================
// Reference divide
// ==============================
function automatic void ref_fdiv(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [2:0]  rm,
  output logic [31:0] res,
  output fp_flags_t   flg
);
  logic        sq;
  logic        a_nan;
  logic        b_nan;
  logic        a_inf;
  logic        b_inf;
  logic        a_zero;
  logic        b_zero;
  int          ea;
  int          eb;
  int          e;
  logic [63:0] ma;
  logic [63:0] mb;
  logic [63:0] num;
  logic [63:0] q;
  logic [63:0] shifted;
  logic        sticky;
  logic        lost;
  logic [23:0] mant;
  logic        g;
  logic        r;
  logic        s;
  logic        up;
  logic        inexact;
  longint      word;

  flg    = '0;
  sq     = a[31] ^ b[31];
  a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 0);
  b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 0);
  a_inf  = (a[30:23] == 8'hff) && (a[22:0] == 0);
  b_inf  = (b[30:23] == 8'hff) && (b[22:0] == 0);
  a_zero = (a[30:0] == 0);
  b_zero = (b[30:0] == 0);

  // Special results in rule order
  if (a_nan || b_nan) begin
    res    = 32'h7fc0_0000;
    // Quiet bit clear marks a signalling NaN
    flg.nv = (a_nan && !a[22]) || (b_nan && !b[22]);
    return;
  end
  if ((a_inf && b_inf) || (a_zero && b_zero)) begin
    res    = 32'h7fc0_0000;
    flg.nv = 1'b1;
    return;
  end
  if (a_inf) begin
    res = {sq, 8'hff, 23'd0};
    return;
  end
  if (b_inf) begin
    res = {sq, 31'd0};
    return;
  end
  if (b_zero) begin
    res    = {sq, 8'hff, 23'd0};
    flg.dz = 1'b1;
    return;
  end
  if (a_zero) begin
    res = {sq, 31'd0};
    return;
  end

  // Subnormals start at exponent 1 and move up to a leading one
  ea = a[30:23];
  ma = a[22:0];
  if (ea == 0) begin
    ea = 1;
    while (!ma[23]) begin
      ma = ma << 1;
      ea--;
    end
  end else begin
    ma[23] = 1'b1;
  end
  eb = b[30:23];
  mb = b[22:0];
  if (eb == 0) begin
    eb = 1;
    while (!mb[23]) begin
      mb = mb << 1;
      eb--;
    end
  end else begin
    mb[23] = 1'b1;
  end

  // Quotient with its leading one at bit 26
  num = ma << 26;
  e   = ea - eb + 127;
  if (ma < mb) begin
    num = num << 1;
    e   = e - 1;
  end
  q      = num / mb;
  sticky = (num % mb) != 0;

  // Below the normal range the quotient slides right
  shifted = q;
  lost    = sticky;
  if (e <= 0) begin
    if (1 - e >= 40) begin
      shifted = '0;
      lost    = 1'b1;
    end else begin
      shifted = q >> (1 - e);
      lost    = sticky || ((q & ((64'd1 << (1 - e)) - 64'd1)) != 0);
    end
    e = 0;
  end
  mant    = shifted[26:3];
  g       = shifted[2];
  r       = shifted[1];
  s       = shifted[0] || lost;
  inexact = g || r || s;

  case (rm)
    3'd1:    up = 1'b0;
    3'd2:    up = sq && inexact;
    3'd3:    up = !sq && inexact;
    3'd4:    up = g;
    default: up = g && (r || s || mant[0]);
  endcase

  // Carry out of the fraction lands in the exponent field
  word = longint'(e) * (longint'(1) << 23) + longint'(mant[22:0]) + longint'(up);
  if (word >= 255 * (longint'(1) << 23)) begin
    flg.of = 1'b1;
    flg.nx = 1'b1;
    if (rm == 3'd1 || (rm == 3'd2 && !sq) || (rm == 3'd3 && sq)) begin
      res = {sq, 31'h7f7f_ffff};
    end else begin
      res = {sq, 8'hff, 23'd0};
    end
  end else begin
    res    = {sq, word[30:0]};
    flg.nx = inexact;
    flg.uf = inexact && (word < (longint'(1) << 23));
  end
endfunction

`endif

//--- testbench/fp_divider_tb.sv
module fp_divider_tb
  import fp_div_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic        i_clk;
  logic        i_rst;
  logic        i_valid;
  logic [31:0] i_operand_a;
  logic [31:0] i_operand_b;
  round_mode_e i_rounding_mode;
  logic        o_valid;
  logic [31:0] o_result;
  fp_flags_t   o_flags;
  logic        o_busy;

  // Expected results queued per accepted strobe
  logic [31:0] exp_res_q[$];
  fp_flags_t   exp_flag_q[$];
  int          exp_lat_q[$];
  int          n_results = 0;
  int          cycle_cnt = 0;
  int          strobe_cycle = 0;
  string       cur_op;

  `include "fp_div_ref.svh"

  fp_divider u_fp_divider (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_operand_a     (i_operand_a),
    .i_operand_b     (i_operand_b),
    .i_rounding_mode (i_rounding_mode),
    .o_valid         (o_valid),
    .o_result        (o_result),
    .o_flags         (o_flags),
    .o_busy          (o_busy)
  );

  // 8 ns clock
  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ==============================
  // Checks
  // ==============================
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      fail_now($sformatf("Fail %s: expected 0x%08h got 0x%08h (%s)", name, want, got, cur_op));
    end
  endtask

  task automatic check_flags(input string name, input fp_flags_t got, input fp_flags_t want);
    if (got !== want) begin
      fail_now($sformatf("Fail %s: expected 0x%02h got 0x%02h (%s)", name, want, got, cur_op));
    end
  endtask

  // Zero, inf and NaN skip the divide loop
  function automatic bit has_special_operand(input logic [31:0] a, input logic [31:0] b);
    return (a[30:23] == 8'hff) || (a[30:0] == '0) || (b[30:23] == 8'hff) || (b[30:0] == '0);
  endfunction

  // Outputs are stable at the falling edge
  always @(negedge i_clk) begin
    int lat;
    int want_lat;
    if (!i_rst && o_valid) begin
      if (exp_res_q.size() == 0) begin
        fail_now("o_valid pulsed with no operation outstanding");
      end else begin
        check_result("o_result", o_result, exp_res_q.pop_front());
        check_flags("o_flags", o_flags, exp_flag_q.pop_front());
        lat      = cycle_cnt - strobe_cycle;
        want_lat = exp_lat_q.pop_front();
        if (lat != want_lat) begin
          fail_now($sformatf("o_valid came %0d cycles after the strobe, not %0d", lat, want_lat));
        end
        if (o_busy !== 1'b0) begin
          fail_now($sformatf("Fail o_busy: expected 0x0 got 0x%h", o_busy));
        end
        n_results++;
      end
    end
  end

  // ==============================
  // Stimulus
  // ==============================
  // Raises the strobe on a falling edge
  task automatic issue_op(input logic [31:0] a, input logic [31:0] b, input round_mode_e rm);
    logic [31:0] er;
    fp_flags_t   ef;
    ref_fdiv(a, b, rm, er, ef);
    exp_res_q.push_back(er);
    exp_flag_q.push_back(ef);
    exp_lat_q.push_back(has_special_operand(a, b) ? 5 : 34);
    cur_op          = $sformatf("%08h / %08h rm %0d", a, b, rm);
    strobe_cycle    = cycle_cnt;
    i_valid         = 1'b1;
    i_operand_a     = a;
    i_operand_b     = b;
    i_rounding_mode = rm;
  endtask

  task automatic wait_result(input int start_count);
    int cycles;
    cycles = 0;
    while (n_results == start_count) begin
      @(posedge i_clk);
      cycles++;
      if (cycles > 100) begin
        fail_now("No o_valid within 100 cycles of the strobe");
      end
    end
  endtask

  task automatic run_op(input logic [31:0] a, input logic [31:0] b, input round_mode_e rm);
    int start_count;
    @(negedge i_clk);
    start_count = n_results;
    issue_op(a, b, rm);
    @(negedge i_clk);
    i_valid = 1'b0;
    wait_result(start_count);
  endtask

  task automatic run_all_modes(input logic [31:0] a, input logic [31:0] b);
    for (int m = 0; m < 5; m++) begin
      run_op(a, b, round_mode_e'(m));
    end
  endtask

  // Busy window and strobes that land inside it
  task automatic busy_test();
    int          cycles;
    logic [31:0] first_res;
    @(negedge i_clk);
    issue_op(32'h4049_0fdb, 32'h402d_f854, RM_RNE);
    first_res = exp_res_q[$];
    @(negedge i_clk);
    i_valid = 1'b0;
    cycles  = 0;
    while (!o_valid) begin
      if (o_busy !== 1'b1) begin
        fail_now($sformatf("Fail o_busy: expected 0x1 got 0x%h", o_busy));
      end
      // 1/0 would give a different word if it were taken
      i_valid     = (cycles == 2) || (cycles == 12);
      i_operand_a = 32'h3f80_0000;
      i_operand_b = 32'h0000_0000;
      @(negedge i_clk);
      cycles++;
      if (cycles > 100) begin
        fail_now("No o_valid within 100 cycles of the strobe");
      end
    end
    i_valid = 1'b0;
    // Room for a stray pulse to show up
    repeat (50) @(negedge i_clk);
    check_result("o_result", o_result, first_res);
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    logic [31:0] a;
    logic [31:0] b;
    i_rst           = 1'b1;
    i_valid         = 1'b0;
    i_operand_a     = '0;
    i_operand_b     = '0;
    i_rounding_mode = RM_RNE;
    cur_op          = "reset";
    repeat (4) @(negedge i_clk);
    i_rst = 1'b0;

    check_result("o_result", o_result, 32'h0);
    check_flags("o_flags", o_flags, '0);
    if (o_valid !== 1'b0 || o_busy !== 1'b0) begin
      fail_now("o_valid or o_busy is high right after reset");
    end

    // Normal operands
    run_all_modes(32'h3f80_0000, 32'h4040_0000);
    run_all_modes(32'hbf80_0000, 32'h4040_0000);
    run_all_modes(32'h40c0_0000, 32'h4040_0000);
    run_all_modes(32'h4049_0fdb, 32'hc02d_f854);

    // Special operands
    run_op(32'h7fc0_0000, 32'h3f80_0000, RM_RNE);
    run_op(32'h3f80_0000, 32'h7f80_0001, RM_RNE);
    run_op(32'hff80_0000, 32'h7f80_0000, RM_RNE);
    run_op(32'h0000_0000, 32'h8000_0000, RM_RTZ);
    run_op(32'hc0a0_0000, 32'h0000_0000, RM_RNE);
    run_op(32'h3f80_0000, 32'hff80_0000, RM_RUP);
    run_op(32'h8000_0000, 32'h4040_0000, RM_RNE);
    run_op(32'h7f80_0000, 32'hc000_0000, RM_RDN);

    // Subnormal operands and underflow
    run_all_modes(32'h0000_0001, 32'h3f80_0000);
    run_all_modes(32'h0040_0000, 32'h4040_0000);
    run_all_modes(32'h0080_0000, 32'h4040_0000);
    run_all_modes(32'h0000_0001, 32'h4000_0000);
    run_all_modes(32'h8000_0003, 32'h7f00_0000);
    run_all_modes(32'h0012_3456, 32'h0000_0789);
    run_all_modes(32'h00ff_ffff, 32'h3f80_0001);

    // Overflow, both signs
    run_all_modes(32'h7f00_0000, 32'h0080_0000);
    run_all_modes(32'hff00_0000, 32'h0080_0000);
    run_all_modes(32'h3f80_0000, 32'h0000_0001);

    busy_test();

    // Random operations
    for (int i = 0; i < 300; i++) begin
      a = gen_operand();
      b = gen_operand();
      run_op(a, b, round_mode_e'(rand_bits(3) % 5));
    end

    // Room for a stray pulse after the last result
    repeat (40) @(negedge i_clk);
    $display("Test OK");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+testbench
verilog/fp_div_pkg.sv
verilog/fp_unpack.sv
verilog/fp_special_case.sv
verilog/fp_mant_divider.sv
verilog/fp_round_pack.sv
verilog/fp_divider.sv
testbench/fp_divider_tb.sv

//--- verilog/fp_div_pkg.sv
package fp_div_pkg;

  // ==============================
  // Single-precision format
  // ==============================
  localparam int EXP_W    = 8;
  localparam int FRAC_W   = 23;
  localparam int MANT_W   = 24;
  localparam int EXP_BIAS = 127;
  localparam int EXP_MAX  = 255;

  // Quotient with 24 mantissa bits and 3 guard bits
  localparam int QUOT_W    = 27;
  localparam int DIV_STEPS = 26;
  // Internal exponent is signed and wide enough for subnormal operands
  localparam int EXPI_W    = 10;

  localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;

  // ==============================
  // Types
  // ==============================
  typedef enum logic [2:0] {
    RM_RNE = 3'd0,
    RM_RTZ = 3'd1,
    RM_RDN = 3'd2,
    RM_RUP = 3'd3,
    RM_RMM = 3'd4
  } round_mode_e;

  // Exception flags, nv in the top bit
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

  typedef struct packed {
    logic is_zero;
    logic is_sub;
    logic is_inf;
    logic is_nan;
    logic is_snan;
  } fp_class_t;

  // Unpacked operand, mant has the leading one at the top unless zero
  typedef struct packed {
    logic                     sign;
    logic signed [EXPI_W-1:0] exp_adj;
    logic [MANT_W-1:0]        mant;
    fp_class_t                cls;
  } fp_operand_t;

  // Divider to rounder
  typedef struct packed {
    logic                     sign;
    logic signed [EXPI_W-1:0] exp;
    logic [QUOT_W-1:0]        quot;
    logic                     sticky;
    logic                     is_zero;
  } fp_quot_t;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_UNPACK,
    ST_DECIDE,
    ST_SETUP,
    ST_DIVIDE,
    ST_NORM,
    ST_RPREP,
    ST_RAPPLY,
    ST_DONE
  } div_state_e;

endpackage

//--- verilog/fp_divider.sv
module fp_divider
  import fp_div_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_valid,
  input  logic [31:0] i_operand_a,
  input  logic [31:0] i_operand_b,
  input  round_mode_e i_rounding_mode,
  output logic        o_valid,
  output logic [31:0] o_result,
  output fp_flags_t   o_flags,
  output logic        o_busy
);

  div_state_e  state;
  div_state_e  state_next;

  // Captured operation
  logic [31:0] opa_q;
  logic [31:0] opb_q;
  round_mode_e rm_q;

  // Stage outputs
  fp_operand_t op_a;
  fp_operand_t op_b;
  logic        is_special;
  logic [31:0] spec_result;
  fp_flags_t   spec_flags;
  logic        div_done;
  fp_quot_t    quot;
  logic [31:0] rnd_result;
  fp_flags_t   rnd_flags;

  // ==============================
  // Control FSM
  // ==============================
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (i_valid) begin
          state_next = ST_UNPACK;
        end
      end
      ST_UNPACK: state_next = ST_DECIDE;
      ST_DECIDE: state_next = ST_SETUP;
      // Special results skip the divide entirely
      ST_SETUP:  state_next = is_special ? ST_DONE : ST_DIVIDE;
      ST_DIVIDE: begin
        if (div_done) begin
          state_next = ST_NORM;
        end
      end
      ST_NORM:   state_next = ST_RPREP;
      ST_RPREP:  state_next = ST_RAPPLY;
      ST_RAPPLY: state_next = ST_DONE;
      ST_DONE:   state_next = ST_IDLE;
      default:   state_next = ST_IDLE;
    endcase
  end

  // Strobes taken only from idle
  always_ff @(posedge i_clk) begin
    if (state == ST_IDLE && i_valid) begin
      opa_q <= i_operand_a;
      opb_q <= i_operand_b;
      rm_q  <= i_rounding_mode;
    end
  end

  // ==============================
  // Stages
  // ==============================
  fp_unpack u_unpack_a (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_en      (state == ST_UNPACK),
    .i_operand (opa_q),
    .o_op      (op_a)
  );

  fp_unpack u_unpack_b (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_en      (state == ST_UNPACK),
    .i_operand (opb_q),
    .o_op      (op_b)
  );

  fp_special_case u_special_case (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_en          (state == ST_DECIDE),
    .i_op_a        (op_a),
    .i_op_b        (op_b),
    .o_is_special  (is_special),
    .o_spec_result (spec_result),
    .o_spec_flags  (spec_flags)
  );

  // Setup only for finite non-zero operands
  fp_mant_divider u_mant_divider (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (state == ST_SETUP && !is_special),
    .i_op_a  (op_a),
    .i_op_b  (op_b),
    .o_done  (div_done),
    .o_quot  (quot)
  );

  fp_round_pack u_round_pack (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_prep   (state == ST_RPREP),
    .i_apply  (state == ST_RAPPLY),
    .i_quot   (quot),
    .i_rm     (rm_q),
    .o_result (rnd_result),
    .o_flags  (rnd_flags)
  );

  // ==============================
  // Outputs
  // ==============================
  // Result holds until the next operation completes
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid  <= 1'b0;
      o_result <= '0;
      o_flags  <= '0;
    end else begin
      o_valid <= (state == ST_DONE);
      if (state == ST_DONE) begin
        if (is_special) begin
          o_result <= spec_result;
          o_flags  <= spec_flags;
        end else begin
          o_result <= rnd_result;
          o_flags  <= rnd_flags;
        end
      end
    end
  end

  // Drops in the o_valid cycle since the FSM is back in idle
  assign o_busy = (state != ST_IDLE);

endmodule

//--- verilog/fp_mant_divider.sv
module fp_mant_divider
  import fp_div_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_start,
  input  fp_operand_t i_op_a,
  input  fp_operand_t i_op_b,
  output logic        o_done,
  output fp_quot_t    o_quot
);

  logic [QUOT_W-1:0]        quot;
  logic [QUOT_W-1:0]        rem;
  logic [QUOT_W-1:0]        divisor;
  logic signed [EXPI_W-1:0] exp_q;
  logic                     sign_q;
  logic [4:0]               step_cnt;
  logic                     stepping;
  logic                     norm_pend;
  logic [QUOT_W-1:0]        rem_sh;
  logic [QUOT_W-1:0]        diff;
  logic [4:0]               q_lzc;

  // One restoring step, sign of diff picks the quotient bit
  assign rem_sh = {rem[QUOT_W-2:0], 1'b0};
  assign diff   = rem_sh - divisor;

  // Leading zeros of the quotient, highest set bit wins
  always_comb begin
    q_lzc = 5'd0;
    for (int i = 0; i < QUOT_W; i++) begin
      if (quot[i]) begin
        q_lzc = 5'(QUOT_W - 1 - i);
      end
    end
  end

  // Last step is taken on the coming edge, normalise follows
  assign o_done = stepping && (step_cnt == 5'(DIV_STEPS - 1));

  // ==============================
  // Sequencing
  // ==============================
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      stepping  <= 1'b0;
      norm_pend <= 1'b0;
      step_cnt  <= '0;
    end else if (i_start) begin
      stepping  <= 1'b1;
      norm_pend <= 1'b0;
      step_cnt  <= '0;
    end else if (stepping) begin
      step_cnt <= step_cnt + 5'd1;
      if (o_done) begin
        stepping  <= 1'b0;
        norm_pend <= 1'b1;
      end
    end else begin
      norm_pend <= 1'b0;
    end
  end

  // ==============================
  // Datapath
  // ==============================
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      sign_q  <= i_op_a.sign ^ i_op_b.sign;
      exp_q   <= i_op_a.exp_adj - i_op_b.exp_adj + EXPI_W'(EXP_BIAS);
      divisor <= QUOT_W'(i_op_b.mant);
      // Integer quotient bit from the mantissa compare
      if (i_op_a.mant >= i_op_b.mant) begin
        quot <= QUOT_W'(1);
        rem  <= QUOT_W'(i_op_a.mant - i_op_b.mant);
      end else begin
        quot <= '0;
        rem  <= QUOT_W'(i_op_a.mant);
      end
    end else if (stepping) begin
      if (diff[QUOT_W-1]) begin
        rem  <= rem_sh;
        quot <= {quot[QUOT_W-2:0], 1'b0};
      end else begin
        rem  <= diff;
        quot <= {quot[QUOT_W-2:0], 1'b1};
      end
    end else if (norm_pend) begin
      // Bring the leading one to the top
      quot  <= quot << q_lzc;
      exp_q <= exp_q - EXPI_W'(q_lzc);
    end
  end

  assign o_quot.sign    = sign_q;
  assign o_quot.exp     = exp_q;
  assign o_quot.quot    = quot;
  assign o_quot.sticky  = |rem;
  assign o_quot.is_zero = (quot == '0) && (rem == '0);

endmodule

//--- verilog/fp_round_pack.sv
module fp_round_pack
  import fp_div_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_prep,
  input  logic        i_apply,
  input  fp_quot_t    i_quot,
  input  round_mode_e i_rm,
  output logic [31:0] o_result,
  output fp_flags_t   o_flags
);

  // Prep stage
  logic [QUOT_W-1:0]        ext;
  logic [QUOT_W-1:0]        shifted;
  logic [EXPI_W-1:0]        shamt;
  logic                     lost;
  logic signed [EXPI_W-1:0] exp_w;
  logic [MANT_W-1:0]        mant_w;
  logic                     g_bit;
  logic                     r_bit;
  logic                     s_bit;
  logic                     round_up;

  // Prep to apply registers
  logic                     sign_p;
  logic signed [EXPI_W-1:0] exp_p;
  logic [MANT_W-1:0]        mant_p;
  logic                     rup_p;
  logic                     inexact_p;
  logic                     zero_p;

  // Apply stage
  logic [MANT_W:0]          rounded;
  logic signed [EXPI_W-1:0] exp_r;
  logic [FRAC_W-1:0]        frac_r;
  logic [31:0]              res_n;
  fp_flags_t                flags_n;

  // ==============================
  // Prep: subnormal shift
  // ==============================
  always_comb begin
    // Mantissa, guard, round, and sticky folded with the remainder
    ext     = {i_quot.quot[QUOT_W-1:1], i_quot.quot[0] | i_quot.sticky};
    shifted = ext;
    shamt   = '0;
    lost    = 1'b0;
    exp_w   = i_quot.exp;
    if (i_quot.exp <= 0) begin
      shamt = EXPI_W'(1) - i_quot.exp;
      if (shamt >= EXPI_W'(QUOT_W)) begin
        shifted = '0;
        lost    = |ext;
      end else begin
        shifted = ext >> shamt;
        // Bits pushed out the bottom
        lost    = |(ext & ~({QUOT_W{1'b1}} << shamt));
      end
      exp_w = '0;
    end
    mant_w = shifted[QUOT_W-1:3];
    g_bit  = shifted[2];
    r_bit  = shifted[1];
    s_bit  = shifted[0] | lost;
  end

  // Round-up per mode, unknown modes behave as RNE
  always_comb begin
    case (i_rm)
      RM_RTZ:  round_up = 1'b0;
      RM_RDN:  round_up = i_quot.sign & (g_bit | r_bit | s_bit);
      RM_RUP:  round_up = ~i_quot.sign & (g_bit | r_bit | s_bit);
      RM_RMM:  round_up = g_bit;
      default: round_up = g_bit & (r_bit | s_bit | mant_w[0]);
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_prep) begin
      sign_p    <= i_quot.sign;
      exp_p     <= exp_w;
      mant_p    <= mant_w;
      rup_p     <= round_up;
      inexact_p <= g_bit | r_bit | s_bit;
      zero_p    <= i_quot.is_zero;
    end
  end

  // ==============================
  // Apply: increment and pack
  // ==============================
  always_comb begin
    rounded = {1'b0, mant_p} + {{MANT_W{1'b0}}, rup_p};
    if (exp_p == '0) begin
      // Subnormal may round up into the smallest normal
      exp_r  = rounded[MANT_W-1] ? EXPI_W'(1) : EXPI_W'(0);
      frac_r = rounded[FRAC_W-1:0];
    end else if (rounded[MANT_W]) begin
      // Carry out, renormalise
      exp_r  = exp_p + EXPI_W'(1);
      frac_r = rounded[MANT_W-1:1];
    end else begin
      exp_r  = exp_p;
      frac_r = rounded[FRAC_W-1:0];
    end

    res_n   = '0;
    flags_n = '0;
    if (zero_p) begin
      res_n = {sign_p, {(EXP_W + FRAC_W){1'b0}}};
    end else if (exp_r >= EXPI_W'(EXP_MAX)) begin
      flags_n.of = 1'b1;
      flags_n.nx = 1'b1;
      // Modes rounding toward zero for this sign saturate
      if ((i_rm == RM_RTZ) ||
          (i_rm == RM_RDN && !sign_p) ||
          (i_rm == RM_RUP && sign_p)) begin
        res_n = {sign_p, EXP_W'(EXP_MAX - 1), {FRAC_W{1'b1}}};
      end else begin
        res_n = {sign_p, EXP_W'(EXP_MAX), {FRAC_W{1'b0}}};
      end
    end else if (exp_r == '0) begin
      flags_n.uf = inexact_p;
      flags_n.nx = inexact_p;
      res_n      = {sign_p, {EXP_W{1'b0}}, frac_r};
    end else begin
      flags_n.nx = inexact_p;
      res_n      = {sign_p, exp_r[EXP_W-1:0], frac_r};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_result <= '0;
      o_flags  <= '0;
    end else if (i_apply) begin
      o_result <= res_n;
      o_flags  <= flags_n;
    end
  end

endmodule

//--- verilog/fp_special_case.sv
module fp_special_case
  import fp_div_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_en,
  input  fp_operand_t i_op_a,
  input  fp_operand_t i_op_b,
  output logic        o_is_special,
  output logic [31:0] o_spec_result,
  output fp_flags_t   o_spec_flags
);

  logic        sign_q;
  logic        special;
  logic [31:0] result;
  logic [31:0] inf_word;
  logic [31:0] zero_word;
  fp_flags_t   flags;

  assign sign_q    = i_op_a.sign ^ i_op_b.sign;
  assign inf_word  = {sign_q, EXP_W'(EXP_MAX), {FRAC_W{1'b0}}};
  assign zero_word = {sign_q, {(EXP_W + FRAC_W){1'b0}}};

  // Rules in priority order, first match wins
  always_comb begin
    special = 1'b1;
    result  = '0;
    flags   = '0;
    if (i_op_a.cls.is_nan || i_op_b.cls.is_nan) begin
      // Only a signalling NaN raises invalid
      result   = CANON_NAN;
      flags.nv = i_op_a.cls.is_snan | i_op_b.cls.is_snan;
    end else if (i_op_a.cls.is_inf && i_op_b.cls.is_inf) begin
      result   = CANON_NAN;
      flags.nv = 1'b1;
    end else if (i_op_a.cls.is_zero && i_op_b.cls.is_zero) begin
      result   = CANON_NAN;
      flags.nv = 1'b1;
    end else if (i_op_a.cls.is_inf) begin
      result = inf_word;
    end else if (i_op_b.cls.is_inf) begin
      result = zero_word;
    end else if (i_op_b.cls.is_zero) begin
      // Dividend is non-zero here
      result   = inf_word;
      flags.dz = 1'b1;
    end else if (i_op_a.cls.is_zero) begin
      result = zero_word;
    end else begin
      special = 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_is_special <= 1'b0;
    end else if (i_en) begin
      o_is_special <= special;
    end
  end

  // Result word and flags
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_spec_result <= result;
      o_spec_flags  <= flags;
    end
  end

endmodule

//--- verilog/fp_unpack.sv
module fp_unpack
  import fp_div_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_en,
  input  logic [31:0] i_operand,
  output fp_operand_t o_op
);

  logic [EXP_W-1:0]  exp_f;
  logic [FRAC_W-1:0] frac_f;
  logic [4:0]        lzc;
  logic [5:0]        shift;
  fp_operand_t       op_next;

  // Field split
  assign exp_f  = i_operand[FRAC_W+EXP_W-1:FRAC_W];
  assign frac_f = i_operand[FRAC_W-1:0];

  // ==============================
  // Leading-zero count of fraction
  // ==============================
  // Scan upward, the highest set bit wins
  always_comb begin
    lzc = 5'd0;
    for (int i = 0; i < FRAC_W; i++) begin
      if (frac_f[i]) begin
        lzc = 5'(FRAC_W - 1 - i);
      end
    end
  end

  // ==============================
  // Classify and normalise
  // ==============================
  always_comb begin
    op_next      = '0;
    op_next.sign = i_operand[31];

    // Class from exponent and fraction fields
    op_next.cls.is_zero = (exp_f == '0) && (frac_f == '0);
    op_next.cls.is_sub  = (exp_f == '0) && (frac_f != '0);
    op_next.cls.is_inf  = (exp_f == EXP_W'(EXP_MAX)) && (frac_f == '0);
    op_next.cls.is_nan  = (exp_f == EXP_W'(EXP_MAX)) && (frac_f != '0);
    // Quiet bit clear means signalling
    op_next.cls.is_snan = op_next.cls.is_nan && !frac_f[FRAC_W-1];

    // One extra position moves the first set bit past the hidden slot
    shift = {1'b0, lzc} + 6'd1;

    if (op_next.cls.is_sub) begin
      // Subnormal: exponent drops below one by the shift
      op_next.exp_adj = EXPI_W'(1) - EXPI_W'(shift);
      op_next.mant    = MANT_W'({1'b0, frac_f} << shift);
    end else if (!op_next.cls.is_zero) begin
      // Normal, inf and NaN carry the hidden one
      op_next.exp_adj = EXPI_W'(exp_f);
      op_next.mant    = {1'b1, frac_f};
    end
  end

  // Output register
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_op <= '0;
    end else if (i_en) begin
      o_op <= op_next;
    end
  end

endmodule
